// File: Bender.yml
package:
  name: riscv_core

sources:
  - source/riscv_pkg.sv
  - source/riscv_regfile.sv
  - source/riscv_pipe_reg.sv
  - source/riscv_dstage.sv
  - source/riscv_estage.sv
  - source/riscv_hazard.sv
  - source/riscv_core.sv
  - target: test
    files:
      - tb/riscv_core_sva.sv
      - tb/riscv_core_tb.sv

// File: riscv_core.f
source/riscv_pkg.sv
source/riscv_regfile.sv
source/riscv_pipe_reg.sv
source/riscv_dstage.sv
source/riscv_estage.sv
source/riscv_hazard.sv
source/riscv_core.sv
tb/riscv_core_sva.sv
tb/riscv_core_tb.sv

// File: source/riscv_core.sv
`timescale 1ns/1ns

module riscv_core (
  input  logic                  i_riscv_core_clk,
  input  logic                  i_arst_n,
  output riscv_pkg::xlen_t      o_imem_addr,
  input  riscv_pkg::inst_t      i_imem_rdata,
  output riscv_pkg::xlen_t      o_dmem_addr,
  output riscv_pkg::xlen_t      o_dmem_wdata,
  output logic                  o_dmem_we,
  output logic                  o_dmem_re,
  input  riscv_pkg::xlen_t      i_dmem_rdata,
  output logic                  o_ret_valid,
  output riscv_pkg::reg_addr_t  o_ret_rd,
  output riscv_pkg::xlen_t      o_ret_data
);

  riscv_pkg::xlen_t       pc;
  riscv_pkg::fd_payload_t fd_f;
  riscv_pkg::fd_payload_t fd_d;
  riscv_pkg::de_payload_t de_d;
  riscv_pkg::de_payload_t de_e;
  riscv_pkg::em_payload_t em_e;
  riscv_pkg::em_payload_t em_m;
  riscv_pkg::mw_payload_t mw_m;
  riscv_pkg::mw_payload_t mw_w;
  riscv_pkg::fwd_sel_e    fwd_a;
  riscv_pkg::fwd_sel_e    fwd_b;
  logic                   stall_f;
  logic                   stall_d;
  logic                   flush_d;
  logic                   flush_e;
  logic                   redirect;
  riscv_pkg::xlen_t       target;
  riscv_pkg::xlen_t       m_result;
  riscv_pkg::xlen_t       wb_result;
  logic [31:0]            ld_word;
  riscv_pkg::xlen_t       load_ext;

  // fetch
  always_ff @(posedge i_riscv_core_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc <= riscv_pkg::RESET_PC;
    end else if (redirect) begin
      pc <= target;
    end else if (!stall_f) begin
      pc <= pc + 64'd4;
    end
  end

  assign o_imem_addr   = pc;
  assign fd_f.pc       = pc;
  assign fd_f.pc_plus4 = pc + 64'd4;
  assign fd_f.inst     = i_imem_rdata;

  riscv_pipe_reg #(.payload_t(riscv_pkg::fd_payload_t)) u_fd_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_en             (!stall_d),
    .i_flush          (flush_d),
    .i_data           (fd_f),
    .o_data           (fd_d)
  );

  riscv_dstage u_riscv_dstage (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_fd             (fd_d),
    .i_wb_we          (mw_w.reg_write),
    .i_wb_rd          (mw_w.rd),
    .i_wb_data        (wb_result),
    .o_de             (de_d)
  );

  riscv_pipe_reg #(.payload_t(riscv_pkg::de_payload_t)) u_de_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_en             (1'b1),
    .i_flush          (flush_e),
    .i_data           (de_d),
    .o_data           (de_e)
  );

  riscv_estage u_riscv_estage (
    .i_de        (de_e),
    .i_fwd_a     (fwd_a),
    .i_fwd_b     (fwd_b),
    .i_m_result  (m_result),
    .i_wb_result (wb_result),
    .o_em        (em_e),
    .o_redirect  (redirect),
    .o_target    (target)
  );

  riscv_pipe_reg #(.payload_t(riscv_pkg::em_payload_t)) u_em_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_en             (1'b1),
    .i_flush          (1'b0),
    .i_data           (em_e),
    .o_data           (em_m)
  );

  // memory stage
  assign o_dmem_addr  = em_m.alu_result;
  assign o_dmem_wdata = em_m.store_data;
  assign o_dmem_we    = em_m.mem_write;
  assign o_dmem_re    = em_m.mem_read;

  // jal in memory forwards its link value
  assign m_result = (em_m.result_src == riscv_pkg::RES_PC4) ? em_m.pc_plus4 : em_m.alu_result;

  // address bit 2 picks the word within the doubleword
  assign ld_word  = em_m.alu_result[2] ? i_dmem_rdata[63:32] : i_dmem_rdata[31:0];
  assign load_ext = (em_m.mem_ext == riscv_pkg::EXT_W) ? {{32{ld_word[31]}}, ld_word}
                                                       : i_dmem_rdata;

  always_comb begin
    mw_m.alu_result = em_m.alu_result;
    mw_m.load_data  = load_ext;
    mw_m.pc_plus4   = em_m.pc_plus4;
    mw_m.rd         = em_m.rd;
    mw_m.result_src = em_m.result_src;
    mw_m.reg_write  = em_m.reg_write;
  end

  riscv_pipe_reg #(.payload_t(riscv_pkg::mw_payload_t)) u_mw_reg (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_en             (1'b1),
    .i_flush          (1'b0),
    .i_data           (mw_m),
    .o_data           (mw_w)
  );

  // writeback
  always_comb begin
    case (mw_w.result_src)
      riscv_pkg::RES_MEM: wb_result = mw_w.load_data;
      riscv_pkg::RES_PC4: wb_result = mw_w.pc_plus4;
      default:            wb_result = mw_w.alu_result;
    endcase
  end

  assign o_ret_valid = mw_w.reg_write && mw_w.rd != '0; // x0 writes are not reported
  assign o_ret_rd    = mw_w.rd;
  assign o_ret_data  = wb_result;

  riscv_hazard u_riscv_hazard (
    .i_rs1_d     (de_d.rs1),
    .i_rs2_d     (de_d.rs2),
    .i_rs1_e     (de_e.rs1),
    .i_rs2_e     (de_e.rs2),
    .i_rd_e      (de_e.rd),
    .i_rd_m      (em_m.rd),
    .i_rd_wb     (mw_w.rd),
    .i_memread_e (de_e.mem_read),
    .i_regw_m    (em_m.reg_write),
    .i_regw_wb   (mw_w.reg_write),
    .i_redirect  (redirect),
    .o_fwd_a     (fwd_a),
    .o_fwd_b     (fwd_b),
    .o_stall_f   (stall_f),
    .o_stall_d   (stall_d),
    .o_flush_d   (flush_d),
    .o_flush_e   (flush_e)
  );

endmodule

// File: source/riscv_dstage.sv
`timescale 1ns/1ns

module riscv_dstage (
  input  logic                    i_riscv_core_clk,
  input  logic                    i_arst_n,
  input  riscv_pkg::fd_payload_t  i_fd,
  input  logic                    i_wb_we,
  input  riscv_pkg::reg_addr_t    i_wb_rd,
  input  riscv_pkg::xlen_t        i_wb_data,
  output riscv_pkg::de_payload_t  o_de
);

  riscv_pkg::inst_t     inst;
  riscv_pkg::reg_addr_t rs1;
  riscv_pkg::reg_addr_t rs2;
  riscv_pkg::reg_addr_t rd;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  riscv_pkg::xlen_t     rs1_data;
  riscv_pkg::xlen_t     rs2_data;
  riscv_pkg::xlen_t     imm_i;
  riscv_pkg::xlen_t     imm_s;
  riscv_pkg::xlen_t     imm_b;
  riscv_pkg::xlen_t     imm_u;
  riscv_pkg::xlen_t     imm_j;

  assign inst   = i_fd.inst;
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // immediates by format, all sign-extended from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  riscv_regfile u_riscv_regfile (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_rs1_addr       (rs1),
    .i_rs2_addr       (rs2),
    .i_we             (i_wb_we),
    .i_rd_addr        (i_wb_rd),
    .i_rd_data        (i_wb_data),
    .o_rs1_data       (rs1_data),
    .o_rs2_data       (rs2_data)
  );

  always_comb begin
    o_de          = '0; // unknown encodings stay a bubble
    o_de.pc       = i_fd.pc;
    o_de.pc_plus4 = i_fd.pc_plus4;
    o_de.rs1_data = rs1_data;
    o_de.rs2_data = rs2_data;
    o_de.rs1      = rs1;
    o_de.rs2      = rs2;
    o_de.rd       = rd;
    case (riscv_pkg::opcode_e'(inst[6:0]))
      riscv_pkg::OPC_OP: begin
        o_de.reg_write = 1'b1;
        case (funct3)
          3'b000:  o_de.alu_op = funct7[5] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
          3'b010:  o_de.alu_op = riscv_pkg::ALU_SLT;
          3'b100:  o_de.alu_op = riscv_pkg::ALU_XOR;
          3'b110:  o_de.alu_op = riscv_pkg::ALU_OR;
          3'b111:  o_de.alu_op = riscv_pkg::ALU_AND;
          default: o_de.reg_write = 1'b0;
        endcase
      end
      riscv_pkg::OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin // addi only
          o_de.reg_write = 1'b1;
          o_de.b_sel_imm = 1'b1;
          o_de.imm       = imm_i;
        end
      end
      riscv_pkg::OPC_LUI: begin
        o_de.reg_write = 1'b1;
        o_de.b_sel_imm = 1'b1;
        o_de.imm       = imm_u;
        o_de.alu_op    = riscv_pkg::ALU_PASS_B;
      end
      riscv_pkg::OPC_LOAD: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          o_de.mem_read   = 1'b1;
          o_de.reg_write  = 1'b1;
          o_de.b_sel_imm  = 1'b1;
          o_de.imm        = imm_i;
          o_de.result_src = riscv_pkg::RES_MEM;
          o_de.mem_ext    = funct3[0] ? riscv_pkg::EXT_D : riscv_pkg::EXT_W;
        end
      end
      riscv_pkg::OPC_STORE: begin
        if (funct3 == 3'b011) begin // sd
          o_de.mem_write = 1'b1;
          o_de.b_sel_imm = 1'b1;
          o_de.imm       = imm_s;
        end
      end
      riscv_pkg::OPC_BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          o_de.branch    = 1'b1;
          o_de.br_ne     = funct3[0];
          o_de.a_sel_pc  = 1'b1; // alu forms the target
          o_de.b_sel_imm = 1'b1;
          o_de.imm       = imm_b;
        end
      end
      riscv_pkg::OPC_JAL: begin
        o_de.jump       = 1'b1;
        o_de.reg_write  = 1'b1;
        o_de.a_sel_pc   = 1'b1;
        o_de.b_sel_imm  = 1'b1;
        o_de.imm        = imm_j;
        o_de.result_src = riscv_pkg::RES_PC4;
      end
      default: ;
    endcase
  end

endmodule

// File: source/riscv_estage.sv
`timescale 1ns/1ns

module riscv_estage (
  input  riscv_pkg::de_payload_t  i_de,
  input  riscv_pkg::fwd_sel_e     i_fwd_a,
  input  riscv_pkg::fwd_sel_e     i_fwd_b,
  input  riscv_pkg::xlen_t        i_m_result,
  input  riscv_pkg::xlen_t        i_wb_result,
  output riscv_pkg::em_payload_t  o_em,
  output logic                    o_redirect,
  output riscv_pkg::xlen_t        o_target
);

  riscv_pkg::xlen_t rs1_val;
  riscv_pkg::xlen_t rs2_val;
  riscv_pkg::xlen_t op_a;
  riscv_pkg::xlen_t op_b;
  riscv_pkg::xlen_t alu_result;
  logic             slt;
  logic             equal;
  logic             taken;

  always_comb begin
    case (i_fwd_a)
      riscv_pkg::FWD_MEM: rs1_val = i_m_result;
      riscv_pkg::FWD_WB:  rs1_val = i_wb_result;
      default:            rs1_val = i_de.rs1_data;
    endcase
  end

  always_comb begin
    case (i_fwd_b)
      riscv_pkg::FWD_MEM: rs2_val = i_m_result;
      riscv_pkg::FWD_WB:  rs2_val = i_wb_result;
      default:            rs2_val = i_de.rs2_data;
    endcase
  end

  assign op_a = i_de.a_sel_pc  ? i_de.pc  : rs1_val;
  assign op_b = i_de.b_sel_imm ? i_de.imm : rs2_val;
  assign slt  = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (i_de.alu_op)
      riscv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      riscv_pkg::ALU_AND:    alu_result = op_a & op_b;
      riscv_pkg::ALU_OR:     alu_result = op_a | op_b;
      riscv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      riscv_pkg::ALU_SLT:    alu_result = {{(riscv_pkg::XLEN-1){1'b0}}, slt};
      riscv_pkg::ALU_PASS_B: alu_result = op_b;
      default:               alu_result = op_a + op_b;
    endcase
  end

  // branch compare uses the forwarded registers, not the alu operands
  assign equal      = rs1_val == rs2_val;
  assign taken      = i_de.branch && (i_de.br_ne ? !equal : equal);
  assign o_redirect = taken || i_de.jump;
  assign o_target   = alu_result; // pc + imm for branches and jal

  always_comb begin
    o_em.alu_result = alu_result;
    o_em.store_data = rs2_val;
    o_em.pc_plus4   = i_de.pc_plus4;
    o_em.rd         = i_de.rd;
    o_em.mem_read   = i_de.mem_read;
    o_em.mem_write  = i_de.mem_write;
    o_em.mem_ext    = i_de.mem_ext;
    o_em.result_src = i_de.result_src;
    o_em.reg_write  = i_de.reg_write;
  end

endmodule

// File: source/riscv_hazard.sv
`timescale 1ns/1ns

module riscv_hazard (
  input  riscv_pkg::reg_addr_t  i_rs1_d,
  input  riscv_pkg::reg_addr_t  i_rs2_d,
  input  riscv_pkg::reg_addr_t  i_rs1_e,
  input  riscv_pkg::reg_addr_t  i_rs2_e,
  input  riscv_pkg::reg_addr_t  i_rd_e,
  input  riscv_pkg::reg_addr_t  i_rd_m,
  input  riscv_pkg::reg_addr_t  i_rd_wb,
  input  logic                  i_memread_e,
  input  logic                  i_regw_m,
  input  logic                  i_regw_wb,
  input  logic                  i_redirect,
  output riscv_pkg::fwd_sel_e   o_fwd_a,
  output riscv_pkg::fwd_sel_e   o_fwd_b,
  output logic                  o_stall_f,
  output logic                  o_stall_d,
  output logic                  o_flush_d,
  output logic                  o_flush_e
);

  logic m_live;
  logic wb_live;
  logic load_use;

  assign m_live  = i_regw_m  && i_rd_m  != '0; // x0 is never forwarded
  assign wb_live = i_regw_wb && i_rd_wb != '0;

  // memory stage is younger, so it wins
  assign o_fwd_a = (m_live  && i_rd_m  == i_rs1_e) ? riscv_pkg::FWD_MEM :
                   (wb_live && i_rd_wb == i_rs1_e) ? riscv_pkg::FWD_WB  : riscv_pkg::FWD_REG;
  assign o_fwd_b = (m_live  && i_rd_m  == i_rs2_e) ? riscv_pkg::FWD_MEM :
                   (wb_live && i_rd_wb == i_rs2_e) ? riscv_pkg::FWD_WB  : riscv_pkg::FWD_REG;

  // load data only exists after the memory stage
  assign load_use = i_memread_e && i_rd_e != '0 && (i_rd_e == i_rs1_d || i_rd_e == i_rs2_d);

  assign o_stall_f = load_use;
  assign o_stall_d = load_use;
  assign o_flush_d = i_redirect;
  assign o_flush_e = load_use || i_redirect; // bubble into execute

endmodule

// File: source/riscv_pipe_reg.sv
`timescale 1ns/1ns

module riscv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_riscv_core_clk,
  input  logic     i_arst_n,
  input  logic     i_en,    // low holds the stage
  input  logic     i_flush, // loads a bubble
  input  payload_t i_data,
  output payload_t o_data
);

  always_ff @(posedge i_riscv_core_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_data <= '0;
    end else if (i_flush) begin
      o_data <= '0; // flush wins over a held stage
    end else if (i_en) begin
      o_data <= i_data;
    end
  end

endmodule

// File: source/riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]           inst_t;

  localparam xlen_t RESET_PC = '0;

  // base opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_e;
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;
  typedef enum logic       {EXT_W, EXT_D} mem_ext_e; // lw sign-extends, ld is raw

  typedef struct packed {
    xlen_t pc;
    xlen_t pc_plus4;
    inst_t inst;
  } fd_payload_t;

  // zero value of every payload is a bubble
  typedef struct packed {
    xlen_t       pc;
    xlen_t       pc_plus4;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    xlen_t       imm;
    alu_op_e     alu_op;
    logic        a_sel_pc;  // operand a from pc
    logic        b_sel_imm; // operand b from immediate
    logic        branch;
    logic        br_ne;     // bne when set, beq otherwise
    logic        jump;
    logic        mem_read;
    logic        mem_write;
    mem_ext_e    mem_ext;
    result_src_e result_src;
    logic        reg_write;
  } de_payload_t;

  typedef struct packed {
    xlen_t       alu_result;
    xlen_t       store_data;
    xlen_t       pc_plus4;
    reg_addr_t   rd;
    logic        mem_read;
    logic        mem_write;
    mem_ext_e    mem_ext;
    result_src_e result_src;
    logic        reg_write;
  } em_payload_t;

  typedef struct packed {
    xlen_t       alu_result;
    xlen_t       load_data;
    xlen_t       pc_plus4;
    reg_addr_t   rd;
    result_src_e result_src;
    logic        reg_write;
  } mw_payload_t;

endpackage

// File: source/riscv_regfile.sv
`timescale 1ns/1ns

module riscv_regfile (
  input  logic                  i_riscv_core_clk,
  input  logic                  i_arst_n,
  input  riscv_pkg::reg_addr_t  i_rs1_addr,
  input  riscv_pkg::reg_addr_t  i_rs2_addr,
  input  logic                  i_we,
  input  riscv_pkg::reg_addr_t  i_rd_addr,
  input  riscv_pkg::xlen_t      i_rd_data,
  output riscv_pkg::xlen_t      o_rs1_data,
  output riscv_pkg::xlen_t      o_rs2_data
);

  riscv_pkg::xlen_t regs [31:1]; // x0 is not stored

  always_ff @(posedge i_riscv_core_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      regs <= '{default: '0};
    end else if (i_we && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  always_comb begin
    if (i_rs1_addr == '0) begin
      o_rs1_data = '0;
    end else if (i_we && i_rs1_addr == i_rd_addr) begin
      o_rs1_data = i_rd_data;
    end else begin
      o_rs1_data = regs[i_rs1_addr];
    end
  end

  always_comb begin
    if (i_rs2_addr == '0) begin
      o_rs2_data = '0;
    end else if (i_we && i_rs2_addr == i_rd_addr) begin
      o_rs2_data = i_rd_data;
    end else begin
      o_rs2_data = regs[i_rs2_addr];
    end
  end

endmodule

// File: tb/riscv_core_stim.txt
# P <instruction hex> | R <rd decimal> <retired value hex>, listed in retirement order
# M <byte address hex> <final doubleword hex>
P 00500093  addi x1, x0, 5
P ffd00113  addi x2, x0, -3
P 002081b3  add  x3, x1, x2
P 40118233  sub  x4, x3, x1
P 001272b3  and  x5, x4, x1
P 0022e333  or   x6, x5, x2
P 001343b3  xor  x7, x6, x1
P 0013a433  slt  x8, x7, x1
P 800004b7  lui  x9, 0x80000
P 10000513  addi x10, x0, 256
P 00953023  sd   x9, 0(x10)
P 00053583  ld   x11, 0(x10)
P 00158613  addi x12, x11, 1 (load-use)
P 00052683  lw   x13, 0(x10)
P 00508663  beq  x1, x5, +12 taken
P 00100713  addi x14, x0, 1 skipped
P 00100793  addi x15, x0, 1 skipped
P 00209663  bne  x1, x2, +12 taken
P 00200713  addi x14, x0, 2 skipped
P 00200793  addi x15, x0, 2 skipped
P 00509463  bne  x1, x5, +8 not taken
P 00c0086f  jal  x16, +12
P 00300713  addi x14, x0, 3 skipped
P 00300793  addi x15, x0, 3 skipped
P 00480893  addi x17, x16, 4
P 01153423  sd   x17, 8(x10)
P 00108033  add  x0, x1, x1 not reported
P 00700913  addi x18, x0, 7
R 1 0000000000000005
R 2 fffffffffffffffd
R 3 0000000000000002
R 4 fffffffffffffffd
R 5 0000000000000005
R 6 fffffffffffffffd
R 7 fffffffffffffff8
R 8 0000000000000001
R 9 ffffffff80000000
R 10 0000000000000100
R 11 ffffffff80000000
R 12 ffffffff80000001
R 13 ffffffff80000000
R 16 0000000000000058
R 17 000000000000005c
R 18 0000000000000007
M 100 ffffffff80000000
M 108 000000000000005c

// File: tb/riscv_core_sva.sv
`timescale 1ns/1ns

module riscv_core_sva (
  input logic                 i_riscv_core_clk,
  input logic                 i_arst_n,
  input riscv_pkg::xlen_t     i_imem_addr,
  input logic                 i_dmem_we,
  input logic                 i_ret_valid,
  input riscv_pkg::reg_addr_t i_ret_rd,
  input logic                 i_stall_f
);

  int fail_count = 0; // failed assertions so far

  dmem_we_in_reset: assert property (@(posedge i_riscv_core_clk) !i_arst_n |-> !i_dmem_we)
    else begin
      $error("o_dmem_we high during reset");
      fail_count++;
    end

  // x0 writes never show up on the retirement port
  ret_rd_nonzero: assert property (@(posedge i_riscv_core_clk) disable iff (!i_arst_n)
    i_ret_valid |-> i_ret_rd != '0)
    else begin
      $error("retirement reported for x0");
      fail_count++;
    end

  imem_aligned: assert property (@(posedge i_riscv_core_clk) disable iff (!i_arst_n)
    i_imem_addr[1:0] == 2'b00)
    else begin
      $error("o_imem_addr not word aligned");
      fail_count++;
    end

  // load-use stall never coincides with a redirect
  pc_holds_on_stall: assert property (@(posedge i_riscv_core_clk) disable iff (!i_arst_n)
    i_stall_f |=> $stable(i_imem_addr))
    else begin
      $error("o_imem_addr moved during a fetch stall");
      fail_count++;
    end

endmodule

// File: tb/riscv_core_tb.sv
`timescale 1ns/1ns

module riscv_core_tb;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 4;
  localparam int    CYC_PER_INSN = 3;   // watchdog budget per program word
  localparam int    WDOG_MARGIN  = 50;
  localparam int    MEM_WORDS    = 256;
  localparam string STIM_FILE    = "tb/riscv_core_stim.txt";

  logic                 clk;
  logic                 arst_n;
  riscv_pkg::xlen_t     imem_addr;
  riscv_pkg::inst_t     imem_rdata;
  riscv_pkg::xlen_t     dmem_addr;
  riscv_pkg::xlen_t     dmem_wdata;
  logic                 dmem_we;
  logic                 dmem_re;
  riscv_pkg::xlen_t     dmem_rdata;
  logic                 ret_valid;
  riscv_pkg::reg_addr_t ret_rd;
  riscv_pkg::xlen_t     ret_data;

  riscv_pkg::inst_t     imem [MEM_WORDS];
  riscv_pkg::xlen_t     dmem [MEM_WORDS];
  riscv_pkg::xlen_t     shadow [32]; // register state seen on the retirement port

  riscv_pkg::reg_addr_t exp_rd [$];
  riscv_pkg::xlen_t     exp_data [$];
  riscv_pkg::xlen_t     exp_maddr [$];
  riscv_pkg::xlen_t     exp_mdata [$];

  int n_prog;
  int ret_count;
  int err_count;
  int tests_run;
  int tests_failed;
  bit stim_loaded;

  riscv_core dut_i (
    .i_riscv_core_clk (clk),
    .i_arst_n         (arst_n),
    .o_imem_addr      (imem_addr),
    .i_imem_rdata     (imem_rdata),
    .o_dmem_addr      (dmem_addr),
    .o_dmem_wdata     (dmem_wdata),
    .o_dmem_we        (dmem_we),
    .o_dmem_re        (dmem_re),
    .i_dmem_rdata     (dmem_rdata),
    .o_ret_valid      (ret_valid),
    .o_ret_rd         (ret_rd),
    .o_ret_data       (ret_data)
  );

  bind riscv_core riscv_core_sva sva_i (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_arst_n         (i_arst_n),
    .i_imem_addr      (o_imem_addr),
    .i_dmem_we        (o_dmem_we),
    .i_ret_valid      (o_ret_valid),
    .i_ret_rd         (o_ret_rd),
    .i_stall_f        (stall_f)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // both memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem_re ? dmem[dmem_addr[10:3]] : '0; // data only on a read

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[10:3]] <= dmem_wdata; // sd is the only store
    end
  end

  task automatic check_xlen(input string name, input riscv_pkg::xlen_t got,
                            input riscv_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_reg(input string name, input riscv_pkg::reg_addr_t got,
                           input riscv_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %-10s passed", name);
    end else begin
      tests_failed++;
      $display("test %-10s failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic load_stim(output bit ok);
    int               fd;
    string            line;
    byte              tag;
    int               rd_idx;
    riscv_pkg::xlen_t a;
    riscv_pkg::xlen_t d;
    ok = 1'b0;
    n_prog = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 3 || line.getc(0) == "#") begin
        continue;
      end
      tag = line.getc(0);
      case (tag)
        "P": begin
          void'($sscanf(line, "%c %h", tag, a));
          if (n_prog < MEM_WORDS) begin
            imem[n_prog] = a[31:0];
            n_prog++;
          end
        end
        "R": begin
          void'($sscanf(line, "%c %d %h", tag, rd_idx, d));
          exp_rd.push_back(rd_idx[4:0]);
          exp_data.push_back(d);
        end
        "M": begin
          void'($sscanf(line, "%c %h %h", tag, a, d));
          exp_maddr.push_back(a);
          exp_mdata.push_back(d);
        end
        default: begin
          $display("stim line not understood: %s", line);
          err_count++;
        end
      endcase
    end
    $fclose(fd);
    ok = n_prog > 0 && exp_rd.size() > 0;
  endtask

  // last retired value per register, zero where nothing retired
  task automatic check_registers();
    riscv_pkg::xlen_t final_val [32];
    for (int r = 0; r < 32; r++) begin
      final_val[r] = '0;
    end
    for (int i = 0; i < exp_rd.size(); i++) begin
      final_val[exp_rd[i]] = exp_data[i];
    end
    for (int r = 1; r < 32; r++) begin
      check_xlen($sformatf("x%0d", r), shadow[r], final_val[r]);
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < exp_maddr.size(); i++) begin
      check_xlen($sformatf("dmem[%h]", exp_maddr[i]), dmem[exp_maddr[i][10:3]],
                 exp_mdata[i]);
    end
  endtask

  always @(negedge clk) begin
    if (arst_n && ret_valid) begin
      if (ret_count < exp_rd.size()) begin
        check_reg("o_ret_rd", ret_rd, exp_rd[ret_count]);
        check_xlen("o_ret_data", ret_data, exp_data[ret_count]);
      end else begin
        $display("unexpected retirement of x%0d after the expected sequence", ret_rd);
        err_count++;
      end
      shadow[ret_rd] = ret_data;
      ret_count++;
    end
  end

  initial begin
    int limit;
    wait (stim_loaded);
    limit = n_prog * CYC_PER_INSN + WDOG_MARGIN;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d writes retired", limit, ret_count,
             exp_rd.size());
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int mark;
    bit ok;
    clk          = 1'b0;
    arst_n       = 1'b0;
    ret_count    = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    stim_loaded  = 1'b0;
    void'($urandom(32));
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = 32'h0000_0013; // nop past the program
      dmem[i] <= {$urandom(), $urandom()};
    end
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    load_stim(ok);
    stim_loaded = 1'b1;
    if (!ok) begin
      $display("stim file %s is missing or has no program or expected lines", STIM_FILE);
      err_count++;
    end

    mark = err_count;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_flag("o_ret_valid", ret_valid, 1'b0);
    check_flag("o_dmem_we", dmem_we, 1'b0);
    check_flag("o_dmem_re", dmem_re, 1'b0);
    check_xlen("o_imem_addr", imem_addr, riscv_pkg::RESET_PC);
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_flag("o_ret_valid", ret_valid, 1'b0);
    check_flag("o_dmem_we", dmem_we, 1'b0);
    check_flag("o_dmem_re", dmem_re, 1'b0);
    check_xlen("o_imem_addr", imem_addr, riscv_pkg::RESET_PC); // first fetch
    report_test("reset", mark);

    if (ok) begin
      mark = err_count;
      wait (ret_count >= exp_rd.size());
      @(negedge clk);
      report_test("retire", mark);
      mark = err_count;
      check_registers();
      report_test("registers", mark);
      mark = err_count;
      check_memory();
      report_test("memory", mark);
    end

    mark = err_count;
    if (dut_i.sva_i.fail_count != 0) begin
      $display("%0d assertion failures in the bound checker", dut_i.sva_i.fail_count);
      err_count++;
    end
    report_test("assertions", mark);

    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
